// File: px.f
+incdir+.
px_pkg.sv
px_config.sv
px_state.sv
px_intr.sv
px_bus.sv
px_top.sv
tb_px.sv

// File: px_bus.sv
// ======================================
// PX bus unit
// Request and answer wait with alarm,
// awaria and hlt_n flags, write deny
// ======================================

module px_bus (
	input  logic got,
	input  logic clo,
	input  logic rd,             // Read cycle wanted
	input  logic wr,             // Write cycle wanted
	input  logic io,             // Cycle exempt from low memory guard
	input  logic ar_low,         // Address in low memory
	input  logic zw,             // Grant
	input  logic rok,            // OK answer
	input  logic ren,            // EN answer, no memory
	input  logic halt,
	input  logic start,
	input  logic cfg_stop_nomem,
	input  logic cfg_low_deny,
	output logic zg,             // Bus request
	output logic bus_done,
	output logic bus_fault,
	output logic awaria,
	output logic hlt_n,
	output logic write_strobe
);

	import px_pkg::*;

	logic [TIMER_W-1:0] timer;     // Waiting cycles without answer
	logic               ar_low_q;  // Address class of last fetch
	logic               answer;
	logic               timeout;
	logic               fault_now;
	logic               deny;
	logic               idle_ok;

	assign answer    = zg && zw && (rok || ren);
	assign timeout   = zg && !answer && (timer == TIMER_W'(ALARM_TICKS - 1));
	assign fault_now = (answer && ren) || timeout;
	assign deny      = wr && !io && ar_low_q && cfg_low_deny; // Store below guard
	assign idle_ok   = !zg && !bus_done && !bus_fault; // Previous cycle fully released

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			zg           <= 1'b0;
			bus_done     <= 1'b0;
			bus_fault    <= 1'b0;
			write_strobe <= 1'b0;
			timer        <= '0;
		end else begin
			bus_done     <= 1'b0; // Pulses by default
			bus_fault    <= 1'b0;
			write_strobe <= 1'b0;
			if (answer) begin
				zg           <= 1'b0; // Drops in the next cycle
				bus_done     <= 1'b1;
				bus_fault    <= ren;
				write_strobe <= wr && rok && !ren;
				timer        <= '0;
			end else if (timeout) begin
				zg        <= 1'b0;
				bus_fault <= 1'b1; // Alarm
				timer     <= '0;
			end else if (zg) begin
				timer <= timer + 1'b1;
			end else if (idle_ok && (rd || wr)) begin
				if (deny) begin
					bus_done <= 1'b1; // Denied store ends without touching the bus
				end else begin
					zg    <= 1'b1;
					timer <= '0;
				end
			end
		end
	end

	// Failure and halt flags
	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			awaria <= 1'b0;
			hlt_n  <= 1'b1;
		end else begin
			if (fault_now) begin
				awaria <= 1'b1; // Sticky until clear
			end
			if (halt || (fault_now && cfg_stop_nomem)) begin
				hlt_n <= 1'b0;
			end else if (start) begin
				hlt_n <= 1'b1; // Restart releases the stop
			end
		end
	end

	// Low memory flag follows every completed read, last one before WW is K1
	always_ff @(posedge got) begin
		if (bus_done && rd) begin
			ar_low_q <= ar_low;
		end
	end

endmodule

// File: px_config.sv
// ======================================
// PX option register
// Stop on missing memory and low memory
// write deny bits for the bus unit
// ======================================

module px_config (
	input  logic got,
	input  logic clo,
	input  logic cfg_we,         // Load strobe
	input  logic cfg_stop_in,    // New stop on nomem value
	input  logic cfg_deny_in,    // New low memory deny value
	output logic cfg_stop_nomem,
	output logic cfg_low_deny
);

	// Both options off after general clear
	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			cfg_stop_nomem <= 1'b0;
			cfg_low_deny   <= 1'b0;
		end else if (cfg_we) begin
			cfg_stop_nomem <= cfg_stop_in; // Halt CPU on EN or alarm
			cfg_low_deny   <= cfg_deny_in; // Guard low memory stores
		end
	end

endmodule

// File: px_intr.sv
// ======================================
// PX interrupt phase sequencer
// Runs I1 to I5 with bus cycles in I1 I2
// ======================================

module px_intr (
	input  logic                got,
	input  logic                clo,
	input  logic                intr_start, // From P5 with przerw
	input  logic                bus_done,
	output px_pkg::intr_phase_t phase,
	output logic                intr_read,  // Vector fetch
	output logic                intr_write, // Return address store
	output logic                intr_done
);

	import px_pkg::*;

	intr_phase_t phase_nx;

	always_comb begin
		phase_nx = phase;
		case (phase)
			ph_none: begin
				if (intr_start) begin
					phase_nx = ph_i1;
				end
			end
			ph_i1: begin
				if (bus_done) begin
					phase_nx = ph_i2; // Vector in
				end
			end
			ph_i2: begin
				if (bus_done) begin
					phase_nx = ph_i3; // Return address out
				end
			end
			ph_i3:   phase_nx = ph_i4;
			ph_i4:   phase_nx = ph_i5;
			ph_i5:   phase_nx = ph_none;
			default: phase_nx = ph_none;
		endcase
	end

	// Own phase register, cleared also by a bus fault from the top
	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			phase <= ph_none;
		end else begin
			phase <= phase_nx;
		end
	end

	assign intr_read  = (phase == ph_i1);
	assign intr_write = (phase == ph_i2);
	assign intr_done  = (phase == ph_i5); // Leaving I5 on this edge

endmodule

// File: px_pkg.sv
// ======================================
// PX shared definitions
// State, opcode and interrupt phase codes
// plus bus timing constants
// ======================================

package px_pkg;

	// Main sequencer states
	typedef enum logic [2:0] {
		st_p0  = 3'd0, // Idle, waiting for start
		st_k1  = 3'd1, // Instruction fetch
		st_p1  = 3'd2, // Decode
		st_wr  = 3'd3, // Data read
		st_ww  = 3'd4, // Data write
		st_p5  = 3'd5, // End of instruction
		st_int = 3'd6  // Interrupt entry in progress
	} cpu_state_t;

	// Instruction class seen at decode
	typedef enum logic [2:0] {
		op_nop   = 3'd0, // Straight to P5
		op_load  = 3'd1, // Memory read
		op_store = 3'd2, // Memory write
		op_in    = 3'd3, // I/O read
		op_ou    = 3'd4, // I/O write
		op_halt  = 3'd5  // Back to P0 and drop hlt_n
	} op_t;

	// Interrupt entry phases
	typedef enum logic [2:0] {
		ph_none = 3'd0, // No interrupt running
		ph_i1   = 3'd1, // Vector read
		ph_i2   = 3'd2, // Return address write
		ph_i3   = 3'd3,
		ph_i4   = 3'd4,
		ph_i5   = 3'd5  // Last phase then hand back
	} intr_phase_t;

	// Bus timing
	localparam int ALARM_TICKS = 8; // Waiting cycles before alarm
	localparam int TIMER_W     = 4; // Timeout counter width

endpackage

// File: px_state.sv
// ======================================
// PX main state sequencer
// P0 K1 P1 WR WW P5 and interrupt hand-off
// with end of cycle pulse
// ======================================

module px_state (
	input  logic                got,
	input  logic                clo,
	input  logic                start,      // Begin next instruction
	input  logic                przerw,     // Interrupt pending
	input  logic                bus_done,   // Bus cycle finished
	input  logic                bus_fault,  // EN answer or alarm
	input  logic                intr_done,  // Interrupt entry finished
	input  px_pkg::op_t         opcode,     // Instruction class from bus
	output px_pkg::cpu_state_t  state,
	output logic                ekc,        // End of cycle
	output logic                intr_start,
	output logic                bus_read,
	output logic                bus_write,
	output logic                bus_io,
	output logic                halt        // Drop hlt_n request
);

	import px_pkg::*;

	cpu_state_t state_nx;
	op_t        op_q;     // Opcode of current instruction

	// Next state
	always_comb begin
		state_nx = state;
		case (state)
			st_p0: begin
				if (start) begin
					state_nx = st_k1;
				end
			end
			st_k1: begin
				if (bus_done) begin
					state_nx = st_p1; // Fetch done
				end
			end
			st_p1: begin
				case (op_q)
					op_load, op_in:  state_nx = st_wr;
					op_store, op_ou: state_nx = st_ww;
					op_halt:         state_nx = st_p0;
					default:         state_nx = st_p5; // nop
				endcase
			end
			st_wr, st_ww: begin
				if (bus_done) begin
					state_nx = st_p5; // Data transfer done
				end
			end
			st_p5: begin
				state_nx = przerw ? st_int : st_p0;
			end
			st_int: begin
				if (intr_done) begin
					state_nx = st_p0;
				end
			end
			default: state_nx = st_p0;
		endcase
		// Failed bus cycle abandons the instruction
		if (bus_fault) begin
			state_nx = st_p0;
		end
	end

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			state <= st_p0;
		end else begin
			state <= state_nx;
		end
	end

	// Opcode taken when the fetch read completes
	always_ff @(posedge got) begin
		if (state == st_k1 && bus_done) begin
			op_q <= opcode;
		end
	end

	assign ekc        = (state == st_p5);
	assign intr_start = (state == st_p5) && przerw; // Same edge as P5 to INT
	assign bus_read   = (state == st_k1) || (state == st_wr);
	assign bus_write  = (state == st_ww);
	assign bus_io     = ((state == st_wr) || (state == st_ww)) &&
		((op_q == op_in) || (op_q == op_ou)); // IN and OU address the I/O space
	assign halt       = (state == st_p1) && (op_q == op_halt);

endmodule

// File: px_top.sv
// ======================================
// PX state control unit top
// Config, sequencer, interrupt and bus
// ======================================

module px_top (
	input  logic                got,
	input  logic                clo,
	input  logic                start,
	input  px_pkg::op_t         opcode,
	input  logic                ar_low,
	input  logic                przerw,
	input  logic                zw,
	input  logic                rok,
	input  logic                ren,
	input  logic                cfg_we,
	input  logic                cfg_stop_in,
	input  logic                cfg_deny_in,
	output px_pkg::cpu_state_t  state,
	output px_pkg::intr_phase_t phase,
	output logic                zg,
	output logic                ekc,
	output logic                awaria,
	output logic                hlt_n,
	output logic                write_strobe
);

	logic cfg_stop_nomem, cfg_low_deny;
	logic st_read, st_write, st_io, halt;
	logic intr_start, intr_done, intr_read, intr_write;
	logic bus_done, bus_fault;
	logic bus_rd, bus_wr, bus_io;
	logic intr_clr;

	assign bus_rd   = st_read | intr_read;
	assign bus_wr   = st_write | intr_write;
	assign bus_io   = st_io | intr_write; // Return address store is never denied
	assign intr_clr = clo | bus_fault;    // Fault aborts interrupt entry

	px_config u_config (
		.got(got), .clo(clo), .cfg_we(cfg_we),
		.cfg_stop_in(cfg_stop_in), .cfg_deny_in(cfg_deny_in),
		.cfg_stop_nomem(cfg_stop_nomem), .cfg_low_deny(cfg_low_deny)
	);

	px_state u_state (
		.got(got), .clo(clo), .start(start), .przerw(przerw),
		.bus_done(bus_done), .bus_fault(bus_fault), .intr_done(intr_done),
		.opcode(opcode), .state(state), .ekc(ekc), .intr_start(intr_start),
		.bus_read(st_read), .bus_write(st_write), .bus_io(st_io), .halt(halt)
	);

	px_intr u_intr (
		.got(got), .clo(intr_clr), .intr_start(intr_start), .bus_done(bus_done),
		.phase(phase), .intr_read(intr_read), .intr_write(intr_write),
		.intr_done(intr_done)
	);

	px_bus u_bus (
		.got(got), .clo(clo), .rd(bus_rd), .wr(bus_wr), .io(bus_io),
		.ar_low(ar_low), .zw(zw), .rok(rok), .ren(ren), .halt(halt),
		.start(start), .cfg_stop_nomem(cfg_stop_nomem), .cfg_low_deny(cfg_low_deny),
		.zg(zg), .bus_done(bus_done), .bus_fault(bus_fault), .awaria(awaria),
		.hlt_n(hlt_n), .write_strobe(write_strobe)
	);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the PX testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_px -f px.f -o tb_px
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_px)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb_px_model.svh
// ======================================
// PX reference model
// Expected state and phase trace, write,
// end of cycle and bus request counts
// ======================================

`ifndef TB_PX_MODEL_SVH
`define TB_PX_MODEL_SVH

typedef enum {ans_ok, ans_en, ans_none} answer_t; // Answer kind for the WR or WW cycle

function automatic void expected_trace(
	input  op_t         op,
	input  logic        przerw_in,
	input  logic        ar_low_in,
	input  logic        stop_nomem,
	input  logic        low_deny,
	input  answer_t     kind,
	output cpu_state_t  states [8],
	output int          n_states,
	output intr_phase_t phases [6],
	output int          n_phases,
	output int          writes,
	output int          ekcs,
	output int          requests,
	output logic        awaria_exp,
	output logic        hlt_n_exp
);
	logic is_read;
	logic is_write;
	logic denied;
	logic uses_bus;
	logic fault;

	is_read  = (op == op_load) || (op == op_in);
	is_write = (op == op_store) || (op == op_ou);
	denied   = (op == op_store) && ar_low_in && low_deny; // OU goes to I/O, never guarded
	uses_bus = (is_read || is_write) && !denied;
	fault    = uses_bus && (kind != ans_ok);                // EN or silence on data cycle

	states   = '{default: st_p0};
	phases   = '{default: ph_none};
	states[1] = st_k1;
	states[2] = st_p1;
	n_states = 3;
	n_phases = 0;
	requests = uses_bus ? 2 : 1; // Fetch always asks the bus
	writes   = 0;
	ekcs     = 0;

	if (is_read || is_write) begin
		states[3] = is_read ? st_wr : st_ww;
		n_states  = 4;
	end
	// Halt and faults skip P5
	if (!fault && (op != op_halt)) begin
		states[n_states] = st_p5;
		n_states = n_states + 1;
		ekcs     = 1;
		writes   = (is_write && !denied) ? 1 : 0;
		if (przerw_in) begin
			states[n_states] = st_int;
			n_states = n_states + 1;
			requests = requests + 2;    // Vector read and return address write
			writes   = writes + 1;
			phases   = '{ph_i1, ph_i2, ph_i3, ph_i4, ph_i5, ph_none};
			n_phases = 6;
		end
	end
	states[n_states] = st_p0;
	n_states   = n_states + 1;
	awaria_exp = fault;
	hlt_n_exp  = !((op == op_halt) || (fault && stop_nomem));
endfunction

`endif

// File: tb_px.sv
// ======================================
// PX state control unit testbench
// Every instruction class against the
// model, with a random bus responder
// ======================================

module tb_px;
	timeunit 1ns;
	timeprecision 100ps;

	import px_pkg::*;

	`include "tb_px_model.svh"

	localparam int          WAIT_LIMIT = 200;          // Cycles before a wait gives up
	localparam int unsigned SEED       = 32'h74acd84a;

	logic        got, clo, start, ar_low, przerw, zw, rok, ren;
	logic        cfg_we, cfg_stop_in, cfg_deny_in;
	op_t         opcode;
	cpu_state_t  state;
	intr_phase_t phase;
	logic        zg, ekc, awaria, hlt_n, write_strobe;

	answer_t     data_answer;  // Given to WR and WW cycles only
	logic        tracking;     // Monitor active
	cpu_state_t  exp_states [8];
	intr_phase_t exp_phases [6];
	int          exp_n_states, exp_n_phases, exp_writes, exp_ekcs, exp_requests;
	logic        exp_awaria, exp_hlt_n;
	int          n_states, n_phases, n_writes, n_ekcs, n_requests;
	cpu_state_t  last_state;
	intr_phase_t last_phase;
	logic        last_zg;

	px_top dut (.*);

	initial begin
		got = 1'b0;
		forever #50 got = ~got;
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_state(input string name, input cpu_state_t actual,
		input cpu_state_t expected);
		if (actual !== expected) begin
			stop_run($sformatf("[ERROR] %0d ns %s: got %s expected %s", $time, name,
				actual.name(), expected.name()));
		end
	endtask

	task automatic check_phase(input string name, input intr_phase_t actual,
		input intr_phase_t expected);
		if (actual !== expected) begin
			stop_run($sformatf("[ERROR] %0d ns %s: got %s expected %s", $time, name,
				actual.name(), expected.name()));
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			stop_run($sformatf("[ERROR] %0d ns %s: got %b expected %b", $time, name,
				actual, expected));
		end
	endtask

	task automatic check_count(input string name, input int actual, input int expected);
		if (actual != expected) begin
			stop_run($sformatf("[ERROR] %0d ns %s: got %0d expected %0d", $time, name,
				actual, expected));
		end
	endtask

	// Bus responder with random grant and answer lags
	initial begin : responder
		int unsigned lag;
		answer_t     kind;
		lag = $urandom(SEED);
		zw  = 1'b0;
		rok = 1'b0;
		ren = 1'b0;
		forever begin
			@(posedge got);
			#5;
			if (zg) begin
				kind = (state == st_wr || state == st_ww) ? data_answer : ans_ok;
				lag  = $urandom_range(3, 0); // Grant lag
				repeat (lag) begin
					@(posedge got);
					#5;
				end
				if (kind != ans_none) begin
					zw  = 1'b1;
					lag = $urandom_range(2, 0); // Answer lag behind grant
					repeat (lag) begin
						@(posedge got);
						#5;
					end
					rok = (kind == ans_ok);
					ren = (kind == ans_en);
					@(posedge got);             // Answer taken here
					#5;
					zw  = 1'b0;
					rok = 1'b0;
					ren = 1'b0;
				end
			end
		end
	end

	// Monitor comparing each state and phase change with the model trace
	initial begin : monitor
		forever begin
			@(negedge got);
			if (tracking) begin
				if (state !== last_state) begin
					if (n_states >= exp_n_states) begin
						stop_run("state changed more often than the model expects");
					end
					check_state("state", state, exp_states[n_states]);
					n_states   = n_states + 1;
					last_state = state;
				end
				if (phase !== last_phase) begin
					if (n_phases >= exp_n_phases) begin
						stop_run("interrupt phase changed more often than the model expects");
					end
					check_phase("phase", phase, exp_phases[n_phases]);
					n_phases   = n_phases + 1;
					last_phase = phase;
				end
				n_writes   = n_writes + (write_strobe ? 1 : 0);
				n_ekcs     = n_ekcs + (ekc ? 1 : 0);
				n_requests = n_requests + ((zg && !last_zg) ? 1 : 0); // New request
				last_zg    = zg;
			end
		end
	end

	task automatic apply_reset();
		clo = 1'b1;
		repeat (3) begin
			@(posedge got);
			#5;
		end
		clo = 1'b0;
		check_state("state", state, st_p0);
		check_phase("phase", phase, ph_none);
		check_flag("zg", zg, 1'b0);
		check_flag("ekc", ekc, 1'b0);
		check_flag("awaria", awaria, 1'b0);
		check_flag("hlt_n", hlt_n, 1'b1);
	endtask

	// One instruction from a clean reset
	task automatic run_case(input op_t op, input logic irq, input logic low,
		input logic stop, input logic deny, input answer_t kind);
		int cycles;
		apply_reset();
		expected_trace(op, irq, low, stop, deny, kind, exp_states, exp_n_states,
			exp_phases, exp_n_phases, exp_writes, exp_ekcs, exp_requests,
			exp_awaria, exp_hlt_n);
		cfg_we      = 1'b1;
		cfg_stop_in = stop;
		cfg_deny_in = deny;
		@(posedge got);
		#5;
		cfg_we      = 1'b0;
		opcode      = op;   // Valid until the fetch completes
		ar_low      = low;
		przerw      = irq;
		data_answer = kind;
		n_states    = 1;    // P0 already seen
		n_phases    = 0;
		n_writes    = 0;
		n_ekcs      = 0;
		n_requests  = 0;
		last_state  = st_p0;
		last_phase  = ph_none;
		last_zg     = zg;
		tracking    = 1'b1;
		start       = 1'b1;
		@(posedge got);
		#5;
		start  = 1'b0;
		cycles = 0;
		while (state != st_p0) begin
			if (cycles == WAIT_LIMIT) begin
				stop_run("timed out waiting for the sequencer to return to P0");
			end
			if (state != st_k1) begin
				opcode = (op == op_halt) ? op_store : op_halt; // Bus fields stale after fetch
				ar_low = !low;
			end
			@(posedge got);
			#5;
			cycles = cycles + 1;
		end
		repeat (2) begin
			@(posedge got);
			#5;
		end
		tracking = 1'b0;
		przerw   = 1'b0;
		check_count("state changes", n_states, exp_n_states);
		check_count("phase changes", n_phases, exp_n_phases);
		check_count("write_strobe pulses", n_writes, exp_writes);
		check_count("ekc pulses", n_ekcs, exp_ekcs);
		check_count("zg requests", n_requests, exp_requests);
		check_flag("awaria", awaria, exp_awaria);
		check_flag("hlt_n", hlt_n, exp_hlt_n);
		check_flag("zg", zg, 1'b0);
	endtask

	initial begin : main
		op_t ops [6];
		int  pass;
		int  k;
		ops         = '{op_nop, op_load, op_store, op_in, op_ou, op_halt};
		clo         = 1'b1;
		start       = 1'b0;
		opcode      = op_nop;
		ar_low      = 1'b0;
		przerw      = 1'b0;
		cfg_we      = 1'b0;
		cfg_stop_in = 1'b0;
		cfg_deny_in = 1'b0;
		data_answer = ans_ok;
		tracking    = 1'b0;
		// Each class three times under fresh random lags
		for (pass = 0; pass < 3; pass++) begin
			for (k = 0; k < 6; k++) begin
				run_case(ops[k], 1'b0, pass[0], 1'b0, 1'b0, ans_ok);
			end
		end
		// Low memory guard
		run_case(op_store, 1'b0, 1'b1, 1'b0, 1'b1, ans_ok);
		run_case(op_ou,    1'b0, 1'b1, 1'b0, 1'b1, ans_ok);
		run_case(op_store, 1'b0, 1'b0, 1'b0, 1'b1, ans_ok);
		// Interrupt entry after P5
		run_case(op_load,  1'b1, 1'b0, 1'b0, 1'b0, ans_ok);
		run_case(op_store, 1'b1, 1'b1, 1'b0, 1'b1, ans_ok);
		run_case(op_nop,   1'b1, 1'b0, 1'b0, 1'b0, ans_ok);
		// EN answer and alarm with and without stop
		run_case(op_load,  1'b0, 1'b0, 1'b0, 1'b0, ans_en);
		run_case(op_in,    1'b0, 1'b0, 1'b1, 1'b0, ans_en);
		run_case(op_store, 1'b0, 1'b0, 1'b0, 1'b0, ans_none);
		run_case(op_ou,    1'b0, 1'b0, 1'b1, 1'b0, ans_none);
		$display("all tests passed");
		$finish;
	end

endmodule
